// File: common/icache_pkg.sv
/*
 * Instruction cache package
 * Fixed cache geometry, fill packet formats, request format and state enums
 */
`default_nettype none

package icache_pkg;

  //////////////////////
  // Geometry
  //////////////////////
  localparam int vaddr_width        = 32;
  localparam int page_offset_width  = 9;
  localparam int ptag_width         = 15;
  // Physical address is {ptag, page offset}
  localparam int paddr_width        = ptag_width + page_offset_width;
  localparam int assoc              = 2;
  localparam int way_id_width       = 1;
  localparam int sets               = 64;
  localparam int block_width        = 64;
  // One bank per way, bank word is also the instruction
  localparam int bank_width         = block_width / assoc;
  localparam int byte_offset_width  = 2;
  localparam int bank_index_width   = 1;
  localparam int set_index_width    = 6;
  localparam int block_offset_width = byte_offset_width + bank_index_width;

  //////////////////////
  // Types
  //////////////////////

  // One way's worth of tag storage
  typedef struct packed {
    logic                  v;
    logic [ptag_width-1:0] tag;
  } tag_info_s;

  typedef enum logic {
    e_set_tag,
    e_clear
  } tag_op_e;

  typedef struct packed {
    tag_op_e                    op;
    logic [set_index_width-1:0] index;
    logic [way_id_width-1:0]    way_id;
    logic [ptag_width-1:0]      tag;
  } tag_pkt_s;

  // Word 0 of the block sits in the low bits
  typedef struct packed {
    logic [set_index_width-1:0] index;
    logic [way_id_width-1:0]    way_id;
    logic [block_width-1:0]     data;
  } data_pkt_s;

  // Always a full block, so no size field
  typedef struct packed {
    logic [paddr_width-1:0] addr;
  } cache_req_s;

  typedef struct packed {
    logic [vaddr_width-1:0] vaddr;
  } fetch_tl_s;

  typedef enum logic {
    e_ready,
    e_miss
  } miss_state_e;

endpackage

`default_nettype wire

// File: icache/icache_tag_mem.sv
/*
 * Tag memory
 * One-port tag array for both ways, tag packet writes and per-way hit compare
 */
`timescale 1ns/1ps
`default_nettype none

module icache_tag_mem (
  input  logic                                  clk_i,
  input  logic                                  reset_i,
  input  logic                                  rd_i,
  input  logic [icache_pkg::set_index_width-1:0] rd_index_i,
  input  logic                                  tag_pkt_v_i,
  input  icache_pkg::tag_pkt_s                  tag_pkt_i,
  output logic                                  tag_pkt_yumi_o,
  input  logic [icache_pkg::ptag_width-1:0]     ptag_i,
  output logic [icache_pkg::assoc-1:0]          hit_way_o
);
  import icache_pkg::*;

  tag_info_s [assoc-1:0] tag_mem [sets];
  tag_info_s [assoc-1:0] rd_info_r;
  logic [assoc-1:0]      wr_mask;
  tag_info_s             wr_info;
  logic                  tag_wr;

  // Fetch reads own the port, packets take the idle cycles
  assign tag_pkt_yumi_o = tag_pkt_v_i & ~rd_i;
  assign tag_wr         = tag_pkt_yumi_o;

  always_comb
  begin
    wr_mask = '0;
    wr_mask[tag_pkt_i.way_id] = 1'b1;
    if (tag_pkt_i.op == e_set_tag)
      wr_info = '{v: 1'b1, tag: tag_pkt_i.tag};
    else
      wr_info = '0;
  end

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      // Invalidate every way of every set
      for (int i = 0; i < sets; i++)
        for (int w = 0; w < assoc; w++)
          tag_mem[i][w].v <= 1'b0;
    end
    else if (tag_wr)
    begin
      for (int w = 0; w < assoc; w++)
        if (wr_mask[w])
          tag_mem[tag_pkt_i.index][w] <= wr_info;
    end
  end

  // Read data holds until the next fetch read
  always_ff @(posedge clk_i)
  begin
    if (rd_i)
      rd_info_r <= tag_mem[rd_index_i];
  end

  always_comb
  begin
    for (int w = 0; w < assoc; w++)
      hit_way_o[w] = rd_info_r[w].v & (rd_info_r[w].tag == ptag_i);
  end

  // A packet left waiting keeps its contents until it is taken
  a_pkt_held: assert property (@(posedge clk_i) disable iff (reset_i)
    tag_pkt_v_i && !tag_pkt_yumi_o |=> tag_pkt_v_i && $stable(tag_pkt_i));

endmodule

`default_nettype wire

// File: icache/icache_data_mem.sv
/*
 * Data memory
 * Two interleaved banks, word w of way k lives in bank (w + k) mod 2
 */
`timescale 1ns/1ps
`default_nettype none

module icache_data_mem (
  input  logic                                    clk_i,
  input  logic                                    rd_i,
  input  logic [icache_pkg::set_index_width-1:0]  rd_index_i,
  input  logic [icache_pkg::bank_index_width-1:0] rd_bank_i,
  input  logic                                    data_pkt_v_i,
  input  icache_pkg::data_pkt_s                   data_pkt_i,
  output logic                                    data_pkt_yumi_o,
  output logic [icache_pkg::assoc-1:0][icache_pkg::bank_width-1:0] bank_data_o
);
  import icache_pkg::*;

  localparam int bank_addr_width = set_index_width + bank_index_width;
  localparam int bank_depth      = sets * assoc;
  localparam int rot_base_width  = $clog2(2 * block_width);

  logic [2*block_width-1:0]             fill_dbl;
  logic [rot_base_width-1:0]            fill_base;
  logic [assoc-1:0][bank_width-1:0]     fill_rot;
  logic                                 fill_wr;
  logic [bank_addr_width-1:0]           rd_addr;

  // Fetch reads win over fill packets
  assign data_pkt_yumi_o = data_pkt_v_i & ~rd_i;
  assign fill_wr         = data_pkt_yumi_o;
  assign rd_addr         = {rd_index_i, rd_bank_i};

  //////////////////////
  // Fill rotate
  //////////////////////

  // Rotate left by way * bank_width
  assign fill_dbl  = {data_pkt_i.data, data_pkt_i.data};
  assign fill_base = rot_base_width'(block_width)
                   - rot_base_width'(data_pkt_i.way_id) * rot_base_width'(bank_width);
  assign fill_rot  = fill_dbl[fill_base +: block_width];

  //////////////////////
  // Banks
  //////////////////////
  for (genvar b = 0; b < assoc; b++)
  begin : g_bank
    logic [bank_width-1:0]       mem [bank_depth];
    logic [bank_index_width-1:0] wr_offset;
    logic [bank_addr_width-1:0]  wr_addr;

    // Word offset held by this bank for the filled way
    assign wr_offset = bank_index_width'(b) - data_pkt_i.way_id;
    assign wr_addr   = {data_pkt_i.index, wr_offset};

    always_ff @(posedge clk_i)
    begin
      if (fill_wr)
        mem[wr_addr] <= fill_rot[b];
    end

    always_ff @(posedge clk_i)
    begin
      if (rd_i)
        bank_data_o[b] <= mem[rd_addr];
    end
  end

endmodule

`default_nettype wire

// File: icache/icache_pipe.sv
/*
 * Fetch pipeline
 * Decode, tag lookup and tag verify stages with hit select and miss detect
 */
`timescale 1ns/1ps
`default_nettype none

module icache_pipe (
  input  logic                                    clk_i,
  input  logic                                    reset_i,
  input  logic                                    v_i,
  input  logic [icache_pkg::vaddr_width-1:0]      vaddr_i,
  input  logic                                    ready_i,
  input  logic                                    yumi_i,
  input  logic [icache_pkg::ptag_width-1:0]       ptag_i,
  input  logic                                    ptag_v_i,
  input  logic [icache_pkg::assoc-1:0]            hit_way_i,
  input  logic [icache_pkg::assoc-1:0][icache_pkg::bank_width-1:0] bank_data_i,
  output logic                                    fetch_rd_o,
  output logic [icache_pkg::set_index_width-1:0]  fetch_index_o,
  output logic [icache_pkg::bank_index_width-1:0] fetch_bank_o,
  output logic [icache_pkg::bank_width-1:0]       data_o,
  output logic                                    data_v_o,
  output logic                                    miss_o,
  output logic [icache_pkg::paddr_width-1:0]      miss_paddr_o
);
  import icache_pkg::*;

  logic                             tl_we;
  logic                             tv_we;
  logic                             v_tl_r;
  fetch_tl_s                        tl_r;
  logic [paddr_width-1:0]           paddr_tl;
  logic                             v_tv_r;
  logic [paddr_width-1:0]           paddr_tv_r;
  logic [assoc-1:0]                 hit_tv_r;
  logic [assoc-1:0][bank_width-1:0] data_tv_r;
  logic [bank_index_width-1:0]      word_tv;
  logic [assoc-1:0]                 bank_sel;

  //////////////////////
  // Decode
  //////////////////////

  // A yumi steals the cycle from new fetches
  assign tl_we         = v_i & ready_i & ~yumi_i;
  assign fetch_rd_o    = tl_we;
  assign fetch_index_o = vaddr_i[block_offset_width +: set_index_width];
  assign fetch_bank_o  = vaddr_i[byte_offset_width +: bank_index_width];

  //////////////////////
  // Tag lookup
  //////////////////////
  always_ff @(posedge clk_i)
  begin
    if (reset_i)
      v_tl_r <= 1'b0;
    else
      v_tl_r <= tl_we;
  end

  always_ff @(posedge clk_i)
  begin
    if (tl_we)
      tl_r.vaddr <= vaddr_i;
  end

  assign paddr_tl = {ptag_i, tl_r.vaddr[page_offset_width-1:0]};
  // No ptag means the fetch is dropped here
  assign tv_we    = v_tl_r & ptag_v_i & ~yumi_i;

  //////////////////////
  // Tag verify
  //////////////////////
  always_ff @(posedge clk_i)
  begin
    if (reset_i)
      v_tv_r <= 1'b0;
    else
      v_tv_r <= tv_we;
  end

  always_ff @(posedge clk_i)
  begin
    if (tv_we)
    begin
      paddr_tv_r <= paddr_tl;
      hit_tv_r   <= hit_way_i;
      data_tv_r  <= bank_data_i;
    end
  end

  assign word_tv = paddr_tv_r[byte_offset_width +: bank_index_width];

  // Bank holding the word is the hit way rotated by the word offset
  always_comb
  begin
    data_o = '0;
    for (int b = 0; b < assoc; b++)
    begin
      bank_sel[b] = hit_tv_r[bank_index_width'(b) - word_tv];
      if (bank_sel[b])
        data_o = data_o | data_tv_r[b];
    end
  end

  assign data_v_o     = v_tv_r & (|hit_tv_r);
  assign miss_o       = v_tv_r & ~(|hit_tv_r);
  assign miss_paddr_o = paddr_tv_r;

  // Tag memory never holds the same ptag in both ways of a set
  a_hit_onehot: assert property (@(posedge clk_i) disable iff (reset_i)
    v_tv_r |-> $onehot0(hit_tv_r));

endmodule

`default_nettype wire

// File: icache/icache_miss_fsm.sv
/*
 * Miss handling FSM
 * Issues the block request and waits in miss until the fill engine completes
 */
`timescale 1ns/1ps
`default_nettype none

module icache_miss_fsm (
  input  logic                               clk_i,
  input  logic                               reset_i,
  input  logic                               miss_i,
  input  logic [icache_pkg::paddr_width-1:0] miss_paddr_i,
  output icache_pkg::cache_req_s             cache_req_o,
  output logic                               cache_req_v_o,
  input  logic                               cache_req_yumi_i,
  input  logic                               cache_req_complete_i,
  output logic                               ready_o
);
  import icache_pkg::*;

  miss_state_e state_r;
  miss_state_e state_n;

  always_comb
  begin
    case (state_r)
      e_ready: state_n = cache_req_yumi_i ? e_miss : e_ready;
      e_miss:  state_n = cache_req_complete_i ? e_ready : e_miss;
      default: state_n = e_ready;
    endcase
  end

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
      state_r <= e_ready;
    else
      state_r <= state_n;
  end

  // Request lives for the TV cycle only
  assign cache_req_v_o    = miss_i & (state_r == e_ready);
  assign cache_req_o.addr = {miss_paddr_i[paddr_width-1:block_offset_width],
                             {block_offset_width{1'b0}}};
  assign ready_o          = (state_r == e_ready);

  a_yumi_needs_req: assert property (@(posedge clk_i) disable iff (reset_i)
    cache_req_yumi_i |-> cache_req_v_o);

endmodule

`default_nettype wire

// File: design/icache_top.sv
/*
 * Instruction cache top level
 * Two-way VIPT cache built from the fetch pipe, tag and data memories and miss FSM
 */
`timescale 1ns/1ps
`default_nettype none

module icache_top (
  input  logic                               clk_i,
  input  logic                               reset_i,
  input  logic                               v_i,
  input  logic [icache_pkg::vaddr_width-1:0] vaddr_i,
  output logic                               ready_o,
  input  logic [icache_pkg::ptag_width-1:0]  ptag_i,
  input  logic                               ptag_v_i,
  output logic [icache_pkg::bank_width-1:0]  data_o,
  output logic                               data_v_o,
  output icache_pkg::cache_req_s             cache_req_o,
  output logic                               cache_req_v_o,
  input  logic                               cache_req_yumi_i,
  input  logic                               cache_req_complete_i,
  input  logic                               tag_pkt_v_i,
  input  icache_pkg::tag_pkt_s               tag_pkt_i,
  output logic                               tag_pkt_yumi_o,
  input  logic                               data_pkt_v_i,
  input  icache_pkg::data_pkt_s              data_pkt_i,
  output logic                               data_pkt_yumi_o
);
  import icache_pkg::*;

  logic                             fetch_rd;
  logic [set_index_width-1:0]       fetch_index;
  logic [bank_index_width-1:0]      fetch_bank;
  logic [assoc-1:0]                 hit_way;
  logic [assoc-1:0][bank_width-1:0] bank_data;
  logic                             miss;
  logic [paddr_width-1:0]           miss_paddr;
  logic                             fsm_ready;

  assign ready_o = fsm_ready;

  icache_pipe u_pipe (
    .clk_i(clk_i), .reset_i(reset_i),
    .v_i(v_i), .vaddr_i(vaddr_i), .ready_i(fsm_ready), .yumi_i(cache_req_yumi_i),
    .ptag_i(ptag_i), .ptag_v_i(ptag_v_i),
    .hit_way_i(hit_way), .bank_data_i(bank_data),
    .fetch_rd_o(fetch_rd), .fetch_index_o(fetch_index), .fetch_bank_o(fetch_bank),
    .data_o(data_o), .data_v_o(data_v_o),
    .miss_o(miss), .miss_paddr_o(miss_paddr)
  );

  icache_tag_mem u_tag_mem (
    .clk_i(clk_i), .reset_i(reset_i),
    .rd_i(fetch_rd), .rd_index_i(fetch_index),
    .tag_pkt_v_i(tag_pkt_v_i), .tag_pkt_i(tag_pkt_i), .tag_pkt_yumi_o(tag_pkt_yumi_o),
    .ptag_i(ptag_i), .hit_way_o(hit_way)
  );

  icache_data_mem u_data_mem (
    .clk_i(clk_i),
    .rd_i(fetch_rd), .rd_index_i(fetch_index), .rd_bank_i(fetch_bank),
    .data_pkt_v_i(data_pkt_v_i), .data_pkt_i(data_pkt_i),
    .data_pkt_yumi_o(data_pkt_yumi_o), .bank_data_o(bank_data)
  );

  icache_miss_fsm u_miss_fsm (
    .clk_i(clk_i), .reset_i(reset_i),
    .miss_i(miss), .miss_paddr_i(miss_paddr),
    .cache_req_o(cache_req_o), .cache_req_v_o(cache_req_v_o),
    .cache_req_yumi_i(cache_req_yumi_i), .cache_req_complete_i(cache_req_complete_i),
    .ready_o(fsm_ready)
  );

endmodule

`default_nettype wire

// File: test/icache_tb.sv
/*
 * Instruction cache testbench
 * Table-driven fetches against a tag model, with a fill engine model for misses
 */
`timescale 1ns/1ps
`default_nettype none

module icache_tb;
  import icache_pkg::*;

  localparam int          clk_half       = 20;
  localparam int          reset_cycles   = 5;
  // 20 entries at up to 15 cycles each, plus reset and margin
  localparam int          max_entries    = 20;
  localparam int          entry_cycles   = 15;
  localparam int          setup_cycles   = 100;
  localparam int          timeout_cycles = max_entries * entry_cycles + setup_cycles;
  localparam logic [31:0] rng_seed       = 32'h2e2b3615;
  localparam logic [31:0] word_key       = 32'h5a5a5a5a;
  localparam logic [1:0]  op_fetch       = 2'd0;
  localparam logic [1:0]  op_pair        = 2'd1;
  localparam logic [1:0]  op_clear       = 2'd2;

  typedef struct packed {
    logic [1:0]            op;
    logic [31:0]           vaddr;
    logic [ptag_width-1:0] ptag;
    logic                  ptag_v;
    logic                  exp_hit;
    logic [2:0]            behavior;
  } entry_s;

  logic clk_i;
  logic reset_i;
  logic v_i;
  logic [vaddr_width-1:0] vaddr_i;
  logic ready_o;
  logic [ptag_width-1:0] ptag_i;
  logic ptag_v_i;
  logic [bank_width-1:0] data_o;
  logic data_v_o;
  cache_req_s cache_req_o;
  logic cache_req_v_o;
  logic cache_req_yumi_i;
  logic cache_req_complete_i;
  logic tag_pkt_v_i;
  tag_pkt_s tag_pkt_i;
  logic tag_pkt_yumi_o;
  logic data_pkt_v_i;
  data_pkt_s data_pkt_i;
  logic data_pkt_yumi_o;

  entry_s                table_q [$];
  logic                  model_v   [sets][assoc];
  logic [ptag_width-1:0] model_tag [sets][assoc];
  int                    errors;
  int                    tests_run;
  int                    tests_failed;
  int                    cycle_count;

  icache_top u_dut (
    .clk_i(clk_i), .reset_i(reset_i),
    .v_i(v_i), .vaddr_i(vaddr_i), .ready_o(ready_o),
    .ptag_i(ptag_i), .ptag_v_i(ptag_v_i),
    .data_o(data_o), .data_v_o(data_v_o),
    .cache_req_o(cache_req_o), .cache_req_v_o(cache_req_v_o),
    .cache_req_yumi_i(cache_req_yumi_i), .cache_req_complete_i(cache_req_complete_i),
    .tag_pkt_v_i(tag_pkt_v_i), .tag_pkt_i(tag_pkt_i), .tag_pkt_yumi_o(tag_pkt_yumi_o),
    .data_pkt_v_i(data_pkt_v_i), .data_pkt_i(data_pkt_i), .data_pkt_yumi_o(data_pkt_yumi_o)
  );

  always #(clk_half) clk_i = ~clk_i;

  always @(posedge clk_i)
  begin
    cycle_count = cycle_count + 1;
    if (cycle_count >= timeout_cycles)
    begin
      $display("Timeout: the run did not end within %0d cycles", timeout_cycles);
      $display("*** FAILED ***");
      $finish;
    end
  end

  ////////////////////
  // Reference model
  ////////////////////
  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // Instruction stored at a physical word address
  function automatic logic [31:0] word_at(input logic [paddr_width-1:0] a);
    return {8'h00, a[paddr_width-1:2], 2'b00} ^ word_key;
  endfunction

  function automatic logic model_hit(input logic [5:0] idx, input logic [ptag_width-1:0] tag);
    return (model_v[idx][0] && model_tag[idx][0] == tag)
        || (model_v[idx][1] && model_tag[idx][1] == tag);
  endfunction

  function automatic logic [31:0] make_vaddr(input logic [22:0] upper, input logic [5:0] idx,
                                             input logic word);
    return {upper, idx, word, 2'b00};
  endfunction

  task automatic flag_error(input string msg);
    $display("ERR %0t: %s", $time, msg);
    errors++;
  endtask

  task automatic add_entry(input logic [1:0] op, input logic [31:0] vaddr,
                           input logic [ptag_width-1:0] ptag, input logic ptag_v,
                           input logic exp_hit, input logic [2:0] behavior);
    entry_s e;
    e = '{op: op, vaddr: vaddr, ptag: ptag, ptag_v: ptag_v, exp_hit: exp_hit,
          behavior: behavior};
    table_q.push_back(e);
  endtask

  task automatic build_table();
    logic [31:0]           rnd;
    logic [22:0]           upper;
    logic [ptag_width-1:0] r0;
    logic [ptag_width-1:0] r1;
    rnd   = xorshift32(rng_seed);
    // Same upper ptag bits, bit 0 puts them in different ways
    r0    = {rnd[15:2], 1'b0};
    r1    = {rnd[15:2], 1'b1};
    upper = 23'(xorshift32(rnd));
    add_entry(op_fetch, make_vaddr(upper, 6'd5, 1'b0), 15'h0a12, 1'b1, 1'b0, 3'd1);
    add_entry(op_fetch, make_vaddr(upper, 6'd5, 1'b0), 15'h0a12, 1'b1, 1'b1, 3'd2);
    add_entry(op_fetch, make_vaddr(upper, 6'd5, 1'b1), 15'h0a12, 1'b1, 1'b1, 3'd2);
    add_entry(op_fetch, make_vaddr(upper, 6'd33, 1'b0), r0, 1'b1, 1'b0, 3'd2);
    add_entry(op_fetch, make_vaddr(upper, 6'd33, 1'b1), r1, 1'b1, 1'b0, 3'd2);
    add_entry(op_fetch, make_vaddr(upper, 6'd33, 1'b0), r0, 1'b1, 1'b1, 3'd2);
    add_entry(op_fetch, make_vaddr(upper, 6'd33, 1'b1), r0, 1'b1, 1'b1, 3'd2);
    add_entry(op_fetch, make_vaddr(upper, 6'd33, 1'b0), r1, 1'b1, 1'b1, 3'd2);
    add_entry(op_fetch, make_vaddr(upper, 6'd33, 1'b1), r1, 1'b1, 1'b1, 3'd2);
    add_entry(op_fetch, make_vaddr(upper, 6'd12, 1'b1), 15'h1235, 1'b1, 1'b0, 3'd3);
    add_entry(op_fetch, make_vaddr(upper, 6'd12, 1'b0), 15'h0444, 1'b1, 1'b0, 3'd3);
    add_entry(op_clear, make_vaddr(upper, 6'd12, 1'b0), 15'h1235, 1'b1, 1'b0, 3'd3);
    add_entry(op_fetch, make_vaddr(upper, 6'd12, 1'b0), 15'h0444, 1'b1, 1'b1, 3'd3);
    add_entry(op_fetch, make_vaddr(upper, 6'd12, 1'b1), 15'h1235, 1'b1, 1'b0, 3'd3);
    add_entry(op_fetch, make_vaddr(upper, 6'd20, 1'b0), 15'h0777, 1'b0, 1'b0, 3'd4);
    add_entry(op_fetch, make_vaddr(upper, 6'd5, 1'b1), 15'h0a12, 1'b0, 1'b0, 3'd4);
    add_entry(op_pair, make_vaddr(upper, 6'd5, 1'b0), 15'h0a12, 1'b1, 1'b1, 3'd5);
    add_entry(op_pair, make_vaddr(upper, 6'd33, 1'b0), r0, 1'b1, 1'b1, 3'd5);
    // Nothing was filled by the dropped fetch
    add_entry(op_fetch, make_vaddr(upper, 6'd20, 1'b0), 15'h0777, 1'b1, 1'b0, 3'd4);
  endtask

  ////////////////////
  // Fill engine
  ////////////////////
  task automatic send_tag(input tag_op_e op, input logic [5:0] idx, input logic way,
                          input logic [ptag_width-1:0] tag);
    tag_pkt_v_i = 1'b1;
    tag_pkt_i   = '{op: op, index: idx, way_id: way, tag: tag};
    #1;
    while (tag_pkt_yumi_o !== 1'b1)
    begin
      @(negedge clk_i);
      #1;
    end
    @(posedge clk_i);
    @(negedge clk_i);
    tag_pkt_v_i = 1'b0;
    model_v[idx][way] = (op == e_set_tag);
    model_tag[idx][way] = tag;
  endtask

  task automatic send_data(input logic [5:0] idx, input logic way, input logic [63:0] blk);
    data_pkt_v_i = 1'b1;
    data_pkt_i   = '{index: idx, way_id: way, data: blk};
    #1;
    while (data_pkt_yumi_o !== 1'b1)
    begin
      @(negedge clk_i);
      #1;
    end
    @(posedge clk_i);
    @(negedge clk_i);
    data_pkt_v_i = 1'b0;
  endtask

  task automatic service_miss(input logic [31:0] vaddr, input logic [ptag_width-1:0] ptag);
    logic [paddr_width-1:0] base;
    logic [5:0]             idx;
    idx  = vaddr[8:3];
    base = {ptag, idx, 3'b000};
    if (cache_req_o.addr !== base)
      flag_error($sformatf("request addr %h, expected %h", cache_req_o.addr, base));
    cache_req_yumi_i = 1'b1;
    @(posedge clk_i);
    @(negedge clk_i);
    cache_req_yumi_i = 1'b0;
    if (ready_o !== 1'b0)
      flag_error("ready_o high after the request was taken");
    send_tag(e_set_tag, idx, ptag[0], ptag);
    send_data(idx, ptag[0], {word_at(base + 24'd4), word_at(base)});
    if (ready_o !== 1'b0)
      flag_error("ready_o high before complete");
    cache_req_complete_i = 1'b1;
    @(posedge clk_i);
    @(negedge clk_i);
    cache_req_complete_i = 1'b0;
    if (ready_o !== 1'b1)
      flag_error("ready_o low after complete");
  endtask

  ////////////////////
  // Fetch sequences
  ////////////////////
  task automatic check_hit(input logic [paddr_width-1:0] paddr);
    if (data_v_o !== 1'b1)
      flag_error($sformatf("data_v_o low on a hit to %h", paddr));
    else if (data_o !== word_at(paddr))
      flag_error($sformatf("data_o %h, expected %h", data_o, word_at(paddr)));
    if (cache_req_v_o !== 1'b0)
      flag_error("cache_req_v_o high on a hit");
  endtask

  task automatic do_fetch(input entry_s e);
    logic [paddr_width-1:0] paddr;
    paddr = {e.ptag, e.vaddr[8:0]};
    if (ready_o !== 1'b1)
      flag_error("ready_o low when a fetch is offered");
    v_i     = 1'b1;
    vaddr_i = e.vaddr;
    @(posedge clk_i);
    @(negedge clk_i);
    v_i      = 1'b0;
    ptag_i   = e.ptag;
    ptag_v_i = e.ptag_v;
    @(posedge clk_i);
    @(negedge clk_i);
    ptag_v_i = 1'b0;
    if (e.ptag_v && e.exp_hit)
      check_hit(paddr);
    else if (data_v_o !== 1'b0)
      flag_error("data_v_o high without a hit");
    if (!e.exp_hit && cache_req_v_o !== e.ptag_v)
      flag_error($sformatf("cache_req_v_o %b, expected %b", cache_req_v_o, e.ptag_v));
    if (cache_req_v_o === 1'b1)
      service_miss(e.vaddr, e.ptag);
  endtask

  // Two fetches accepted on consecutive edges
  task automatic do_pair(input entry_s e);
    v_i     = 1'b1;
    vaddr_i = e.vaddr;
    @(posedge clk_i);
    @(negedge clk_i);
    vaddr_i  = e.vaddr | 32'h4;
    ptag_i   = e.ptag;
    ptag_v_i = 1'b1;
    @(posedge clk_i);
    @(negedge clk_i);
    v_i = 1'b0;
    check_hit({e.ptag, e.vaddr[8:0]});
    @(posedge clk_i);
    @(negedge clk_i);
    ptag_v_i = 1'b0;
    check_hit({e.ptag, e.vaddr[8:0] | 9'h4});
  endtask

  initial
  begin
    int errs_before;
    clk_i = 1'b0;
    reset_i = 1'b1;
    v_i = 1'b0;
    vaddr_i = '0;
    ptag_i = '0;
    ptag_v_i = 1'b0;
    cache_req_yumi_i = 1'b0;
    cache_req_complete_i = 1'b0;
    tag_pkt_v_i = 1'b0;
    tag_pkt_i = '0;
    data_pkt_v_i = 1'b0;
    data_pkt_i = '0;
    errors = 0;
    tests_run = 0;
    tests_failed = 0;
    cycle_count = 0;
    for (int s = 0; s < sets; s++)
      for (int w = 0; w < assoc; w++)
        model_v[s][w] = 1'b0;
    build_table();

    repeat (reset_cycles) @(posedge clk_i);
    @(negedge clk_i);
    reset_i = 1'b0;
    if (data_v_o !== 1'b0 || cache_req_v_o !== 1'b0 || ready_o !== 1'b1
        || tag_pkt_yumi_o !== 1'b0 || data_pkt_yumi_o !== 1'b0)
      flag_error("outputs not idle after reset");

    foreach (table_q[i])
    begin
      errs_before = errors;
      if (table_q[i].ptag_v && table_q[i].op != op_clear
          && model_hit(table_q[i].vaddr[8:3], table_q[i].ptag) != table_q[i].exp_hit)
      begin
        $display("Table entry %0d has a hit flag that the tag model does not agree with", i);
        errors++;
      end
      case (table_q[i].op)
        op_pair:  do_pair(table_q[i]);
        op_clear: send_tag(e_clear, table_q[i].vaddr[8:3], table_q[i].ptag[0], table_q[i].ptag);
        default:  do_fetch(table_q[i]);
      endcase
      tests_run++;
      if (errors == errs_before)
        $display("entry %0d (behavior %0d): ok", i, table_q[i].behavior);
      else
      begin
        tests_failed++;
        $display("entry %0d (behavior %0d): failed", i, table_q[i].behavior);
      end
    end

    $display("%0d tests, %0d failed, %0d errors", tests_run, tests_failed, errors);
    if (errors == 0)
      $display("*** PASSED ***");
    else
      $display("*** FAILED ***");
    $finish;
  end

endmodule

`default_nettype wire

// File: sim.f
common/icache_pkg.sv
icache/icache_tag_mem.sv
icache/icache_data_mem.sv
icache/icache_pipe.sv
icache/icache_miss_fsm.sv
design/icache_top.sv
test/icache_tb.sv

// File: run.sh
#!/bin/sh
# Build the instruction cache testbench with Verilator, run it and check the log
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
  -f sim.f --top-module icache_tb -o icache_sim
./obj_dir/icache_sim | tee sim.log

if grep -qxF '*** PASSED ***' sim.log; then
  echo "Simulation passed"
else
  echo "Simulation failed, see sim.log"
  exit 1
fi
